// ==== hdl/bp_cfg_pkg.sv ====
// predictor sizing constants
`default_nettype none

package bp_cfg_pkg;

    // pc layout
    localparam int unsigned PC_WIDTH   = 32;
    localparam int unsigned PHT_IDX_W  = 8;     // 256 counters
    localparam int unsigned PC_ALIGN_W = 2;     // word aligned fetch
    localparam int unsigned PC_TAG_W   = PC_WIDTH - PHT_IDX_W - PC_ALIGN_W;
    localparam int unsigned PHT_DEPTH  = 1 << PHT_IDX_W;

    // defaults picked up by the top level
    localparam int unsigned GH_WIDTH_DEF   = 12;
    localparam int unsigned CKPT_DEPTH_DEF = 8;

    localparam logic [1:0] CTR_WEAK_NT = 2'b01;

endpackage

`default_nettype wire

// ==== hdl/bp_types_pkg.sv ====
// pc word views
`default_nettype none

package bp_types_pkg;

    // fetch writes raw, predict reads the fields
    typedef union packed {
        logic [bp_cfg_pkg::PC_WIDTH-1:0] raw;
        struct packed {
            logic [bp_cfg_pkg::PC_TAG_W-1:0]   tag;    // upper bits, unused by gshare
            logic [bp_cfg_pkg::PHT_IDX_W-1:0]  idx;
            logic [bp_cfg_pkg::PC_ALIGN_W-1:0] align;  // always zero
        } fld;
    } pc_word_u;

endpackage

`default_nettype wire

// ==== hdl/bp_pht.sv ====
// pattern history table
`timescale 1ns/10ps
`default_nettype none

module bp_pht (
    input  wire logic                             clk,
    input  wire logic                             rstn,
    input  wire logic [bp_cfg_pkg::PHT_IDX_W-1:0] rd_idx,
    output logic                                  rd_taken,
    input  wire logic                             upd_en,
    input  wire logic [bp_cfg_pkg::PHT_IDX_W-1:0] upd_idx,
    input  wire logic                             upd_taken,
    output logic                                  init_busy
);
    import bp_cfg_pkg::*;

    logic [1:0]           ctr_mem [PHT_DEPTH];
    logic [PHT_IDX_W-1:0] init_ptr;
    logic [1:0]           upd_old;

    // walk every entry once after reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            init_ptr  <= '0;
            init_busy <= 1'b1;
        end else if (init_busy) begin
            init_ptr <= init_ptr + 1'b1;
            if (&init_ptr) begin
                init_busy <= 1'b0;                  // last entry written
            end
        end
    end

    assign upd_old  = ctr_mem[upd_idx];
    assign rd_taken = ctr_mem[rd_idx][1];           // 2 or 3 means taken

    // same-cycle read sees the old counter
    always_ff @(posedge clk) begin
        if (init_busy) begin
            ctr_mem[init_ptr] <= CTR_WEAK_NT;
        end else if (upd_en) begin
            if (upd_taken && upd_old != 2'b11) begin
                ctr_mem[upd_idx] <= upd_old + 2'd1;
            end else if (!upd_taken && upd_old != 2'b00) begin
                ctr_mem[upd_idx] <= upd_old - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bp_fetch_stage.sv ====
// fetch stage register
`timescale 1ns/10ps
`default_nettype none

module bp_fetch_stage (
    input  wire logic                            clk,
    input  wire logic                            rstn,
    input  wire logic                            fetch_valid,
    input  wire logic [bp_cfg_pkg::PC_WIDTH-1:0] fetch_pc,
    input  wire logic                            stall,
    input  wire logic                            flush,
    output logic                                 f_valid,
    output bp_types_pkg::pc_word_u               f_pc
);
    logic take;

    assign take = fetch_valid && !stall && !flush;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            f_valid <= 1'b0;
        end else if (flush) begin
            f_valid <= 1'b0;        // wrong path item
        end else if (!stall) begin
            f_valid <= fetch_valid; // item moves on, new one comes in
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            f_pc.raw <= fetch_pc;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bp_predict_stage.sv ====
// gshare predict stage
`timescale 1ns/10ps
`default_nettype none

module bp_predict_stage #(
    parameter int unsigned GH_WIDTH = bp_cfg_pkg::GH_WIDTH_DEF
) (
    input  wire logic                             clk,
    input  wire logic                             rstn,
    input  wire logic                             f_valid,
    input  wire bp_types_pkg::pc_word_u           f_pc,
    input  wire logic [GH_WIDTH-1:0]              gh,
    input  wire logic                             stall,
    input  wire logic                             flush,
    input  wire logic                             upd_en,
    input  wire logic [bp_cfg_pkg::PHT_IDX_W-1:0] upd_idx,
    input  wire logic                             upd_taken,
    output logic                                  pred_valid,
    output logic                                  pred_taken,
    output logic [bp_cfg_pkg::PHT_IDX_W-1:0]      pred_idx,
    output logic [GH_WIDTH-1:0]                   pred_hist,
    output logic                                  init_busy
);
    import bp_cfg_pkg::*;

    logic [PHT_IDX_W-1:0] hash_idx;
    logic                 ctr_taken;
    logic                 fire;

    assign hash_idx = f_pc.fld.idx ^ gh[PHT_IDX_W-1:0];
    assign fire     = f_valid && !stall && !flush;

    bp_pht u_pht (
        .clk       (clk),
        .rstn      (rstn),
        .rd_idx    (hash_idx),
        .rd_taken  (ctr_taken),
        .upd_en    (upd_en),
        .upd_idx   (upd_idx),
        .upd_taken (upd_taken),
        .init_busy (init_busy)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= fire;     // one cycle pulse per prediction
        end
    end

    // keep the history used so a checkpoint can restore it
    always_ff @(posedge clk) begin
        if (fire) begin
            pred_taken <= ctr_taken;
            pred_idx   <= hash_idx;
            pred_hist  <= gh;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bp_ghr_ckpt.sv ====
// global history and checkpoint recovery
`timescale 1ns/10ps
`default_nettype none

module bp_ghr_ckpt #(
    parameter int unsigned GH_WIDTH   = bp_cfg_pkg::GH_WIDTH_DEF,
    parameter int unsigned CKPT_DEPTH = bp_cfg_pkg::CKPT_DEPTH_DEF
) (
    input  wire logic                             clk,
    input  wire logic                             rstn,
    input  wire logic                             pred_valid,
    input  wire logic                             pred_taken,
    input  wire logic [bp_cfg_pkg::PHT_IDX_W-1:0] pred_idx,
    input  wire logic [GH_WIDTH-1:0]              pred_hist,
    input  wire logic                             f_valid,
    input  wire logic                             init_busy,
    input  wire logic                             resolve_valid,
    input  wire logic                             resolve_taken,
    output logic [GH_WIDTH-1:0]                   gh,
    output logic                                  flush,
    output logic                                  redirect,
    output logic                                  ckpt_room,
    output logic                                  upd_en,
    output logic [bp_cfg_pkg::PHT_IDX_W-1:0]      upd_idx,
    output logic                                  upd_taken
);
    import bp_cfg_pkg::*;

    localparam int unsigned PTR_W = $clog2(CKPT_DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    // checkpoint queue, circular
    logic [GH_WIDTH-1:0]  ck_gh    [CKPT_DEPTH];
    logic                 ck_taken [CKPT_DEPTH];
    logic [PHT_IDX_W-1:0] ck_idx   [CKPT_DEPTH];

    logic [GH_WIDTH-1:0] gh_q;      // history of all pushed predictions
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic [CNT_W:0]      occupancy;
    logic                push;
    logic                pop;

    // the prediction in flight already counts for the next lookup
    assign gh = pred_valid ? {gh_q[GH_WIDTH-2:0], pred_taken} : gh_q;

    // oldest entry is the one being resolved
    assign flush     = resolve_valid && (resolve_taken != ck_taken[rd_ptr]);
    assign push      = pred_valid && !flush;
    assign pop       = resolve_valid && !flush;

    assign upd_en    = resolve_valid;
    assign upd_idx   = ck_idx[rd_ptr];
    assign upd_taken = resolve_taken;

    // fetch item and registered prediction both still need a slot
    assign occupancy = {1'b0, count} + (CNT_W+1)'(pred_valid) + (CNT_W+1)'(f_valid);
    assign ckpt_room = !init_busy && (occupancy < (CNT_W+1)'(CKPT_DEPTH));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            gh_q     <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            redirect <= 1'b0;
        end else begin
            redirect <= flush;
            if (flush) begin
                // restore and append the real outcome
                gh_q   <= {ck_gh[rd_ptr][GH_WIDTH-2:0], resolve_taken};
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    gh_q   <= gh;
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                count <= count + CNT_W'(push) - CNT_W'(pop);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            ck_gh[wr_ptr]    <= pred_hist;
            ck_taken[wr_ptr] <= pred_taken;
            ck_idx[wr_ptr]   <= pred_idx;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bp_top.sv ====
// gshare direction predictor
`timescale 1ns/10ps
`default_nettype none

module bp_top #(
    parameter int unsigned GH_WIDTH   = bp_cfg_pkg::GH_WIDTH_DEF,
    parameter int unsigned CKPT_DEPTH = bp_cfg_pkg::CKPT_DEPTH_DEF
) (
    input  wire logic                            clk,
    input  wire logic                            rstn,
    input  wire logic                            fetch_valid,
    input  wire logic [bp_cfg_pkg::PC_WIDTH-1:0] fetch_pc,
    input  wire logic                            stall,
    input  wire logic                            resolve_valid,
    input  wire logic                            resolve_taken,
    output logic                                 pred_valid,
    output logic                                 pred_taken,
    output logic [GH_WIDTH-1:0]                  pred_hist,
    output logic                                 redirect,
    output logic                                 ckpt_room
);
    import bp_cfg_pkg::*;
    import bp_types_pkg::*;

    logic                 flush;
    logic                 f_valid;
    pc_word_u             f_pc;
    logic [GH_WIDTH-1:0]  gh;
    logic [PHT_IDX_W-1:0] pred_idx;
    logic                 init_busy;
    logic                 upd_en;
    logic [PHT_IDX_W-1:0] upd_idx;
    logic                 upd_taken;

    bp_fetch_stage u_fetch (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .stall       (stall),
        .flush       (flush),
        .f_valid     (f_valid),
        .f_pc        (f_pc)
    );

    bp_predict_stage #(
        .GH_WIDTH (GH_WIDTH)
    ) u_predict (
        .clk        (clk),
        .rstn       (rstn),
        .f_valid    (f_valid),
        .f_pc       (f_pc),
        .gh         (gh),
        .stall      (stall),
        .flush      (flush),
        .upd_en     (upd_en),
        .upd_idx    (upd_idx),
        .upd_taken  (upd_taken),
        .pred_valid (pred_valid),
        .pred_taken (pred_taken),
        .pred_idx   (pred_idx),
        .pred_hist  (pred_hist),
        .init_busy  (init_busy)
    );

    bp_ghr_ckpt #(
        .GH_WIDTH   (GH_WIDTH),
        .CKPT_DEPTH (CKPT_DEPTH)
    ) u_ghr (
        .clk           (clk),
        .rstn          (rstn),
        .pred_valid    (pred_valid),
        .pred_taken    (pred_taken),
        .pred_idx      (pred_idx),
        .pred_hist     (pred_hist),
        .f_valid       (f_valid),
        .init_busy     (init_busy),
        .resolve_valid (resolve_valid),
        .resolve_taken (resolve_taken),
        .gh            (gh),
        .flush         (flush),
        .redirect      (redirect),
        .ckpt_room     (ckpt_room),
        .upd_en        (upd_en),
        .upd_idx       (upd_idx),
        .upd_taken     (upd_taken)
    );

endmodule

`default_nettype wire

// ==== sim/bp_properties.sv ====
// predictor protocol assertions
`timescale 1ns/10ps
`default_nettype none

module bp_properties (
    input wire logic clk,
    input wire logic rstn,
    input wire logic fetch_valid,
    input wire logic resolve_valid,
    input wire logic flush,
    input wire logic pred_valid,
    input wire logic redirect,
    input wire logic ckpt_room
);
    int n_redirect = 0;
    int n_flush    = 0;
    int n_room     = 0;
    int fail_count;

    assign fail_count = n_redirect + n_flush + n_room;     // over all properties

    redirect_after_resolve: assert property (@(posedge clk) disable iff (!rstn)
        redirect |-> $past(resolve_valid))
    else begin
        $error("redirect seen without a resolve in the previous cycle");
        n_redirect++;
    end

    // wrong path prediction must be squashed
    no_pred_after_flush: assert property (@(posedge clk) disable iff (!rstn)
        $past(flush) |-> !pred_valid)
    else begin
        $error("prediction emitted in the cycle after a flushing resolve");
        n_flush++;
    end

    fetch_needs_room: assert property (@(posedge clk) disable iff (!rstn)
        fetch_valid |-> ckpt_room)
    else begin
        $error("fetch driven while the checkpoint queue had no room");
        n_room++;
    end

endmodule

bind bp_top bp_properties u_props (
    .clk           (clk),
    .rstn          (rstn),
    .fetch_valid   (fetch_valid),
    .resolve_valid (resolve_valid),
    .flush         (flush),
    .pred_valid    (pred_valid),
    .redirect      (redirect),
    .ckpt_room     (ckpt_room)
);

`default_nettype wire

// ==== sim/bp_checker.sv ====
// gshare reference model
`timescale 1ns/10ps
`default_nettype none

module bp_checker #(
    parameter int unsigned GH_WIDTH   = bp_cfg_pkg::GH_WIDTH_DEF,
    parameter int unsigned CKPT_DEPTH = bp_cfg_pkg::CKPT_DEPTH_DEF
) (
    input  wire logic                            clk,
    input  wire logic                            rstn,
    input  wire logic                            fetch_valid,
    input  wire logic [bp_cfg_pkg::PC_WIDTH-1:0] fetch_pc,
    input  wire logic                            stall,
    input  wire logic                            resolve_valid,
    input  wire logic                            resolve_taken,
    input  wire logic                            pred_valid,
    input  wire logic                            pred_taken,
    input  wire logic [GH_WIDTH-1:0]             pred_hist,
    input  wire logic                            redirect,
    input  wire logic                            ckpt_room,
    input  wire logic [2:0]                      test_id,
    input  wire logic                            test_done,
    output logic                                 model_room,
    output int                                   model_count,
    output logic [bp_cfg_pkg::PC_WIDTH-1:0]      oldest_pc,
    output int                                   check_count,
    output int                                   error_count
);
    import bp_cfg_pkg::*;

    logic [1:0]           m_ctr [PHT_DEPTH];
    logic [GH_WIDTH-1:0]  m_gh;             // history of all pushed predictions
    logic [GH_WIDTH-1:0]  q_gh [$];
    logic                 q_taken [$];
    logic [PHT_IDX_W-1:0] q_idx [$];
    logic [PC_WIDTH-1:0]  q_pc [$];
    logic                 m_f_valid;
    logic [PC_WIDTH-1:0]  m_f_pc;
    logic                 m_pv;
    logic                 m_pt;
    logic [PHT_IDX_W-1:0] m_pidx;
    logic [GH_WIDTH-1:0]  m_ph;
    logic [PC_WIDTH-1:0]  m_ppc;
    logic                 m_redirect;
    logic                 m_init_busy;
    int                   m_init_left;
    int                   n_checks = 0;
    int                   n_errors = 0;
    int                   test_checks = 0;
    int                   test_errors = 0;

    assign check_count = n_checks;
    assign error_count = n_errors;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1: return "cold_start";
            3'd2: return "train_taken";
            3'd3: return "steady_hist";
            3'd4: return "mispredict";
            3'd5: return "random_stall";
            default: return "init";
        endcase
    endfunction

    // queue, registered prediction and fetch item each take a slot
    function automatic logic room_now();
        return !m_init_busy &&
               (q_gh.size() + int'(m_pv) + int'(m_f_valid) < int'(CKPT_DEPTH));
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        test_checks++;
        if (exp !== act) begin
            n_errors++;
            test_errors++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name(test_id), what, exp, act);
        end
    endtask

    task automatic report_fault(input string msg);
        n_errors++;
        test_errors++;
        $display("checker fault in %s: %s", test_name(test_id), msg);
    endtask

    task automatic reset_model();
        for (int i = 0; i < int'(PHT_DEPTH); i++) begin
            m_ctr[i] = CTR_WEAK_NT;
        end
        q_gh.delete();
        q_taken.delete();
        q_idx.delete();
        q_pc.delete();
        m_gh        = '0;
        m_f_valid   = 1'b0;
        m_pv        = 1'b0;
        m_redirect  = 1'b0;
        m_init_busy = 1'b1;
        m_init_left = PHT_DEPTH;    // one entry per cycle
        model_room  = 1'b0;
        model_count = 0;
        oldest_pc   = '0;
    endtask

    // advance the model across the next rising edge
    task automatic step_model();
        logic [GH_WIDTH-1:0]  gh_cur;
        logic [PHT_IDX_W-1:0] idx;
        logic [PHT_IDX_W-1:0] ui;
        logic [1:0]           ctr;
        logic                 flush;
        logic                 fire;
        gh_cur = m_pv ? {m_gh[GH_WIDTH-2:0], m_pt} : m_gh;   // in-flight bit counts
        flush  = 1'b0;
        if (resolve_valid && q_gh.size() == 0) begin
            report_fault("resolve driven with no checkpoint outstanding");
        end else if (resolve_valid) begin
            flush = (resolve_taken != q_taken[0]);
        end
        fire = m_f_valid && !stall && !flush;
        idx  = m_f_pc[PC_ALIGN_W +: PHT_IDX_W] ^ gh_cur[PHT_IDX_W-1:0];
        ctr  = m_ctr[idx];          // old value even if updated now
        if (resolve_valid && q_gh.size() != 0) begin
            ui = q_idx[0];
            if (resolve_taken && m_ctr[ui] != 2'b11) begin
                m_ctr[ui] = m_ctr[ui] + 2'd1;
            end else if (!resolve_taken && m_ctr[ui] != 2'b00) begin
                m_ctr[ui] = m_ctr[ui] - 2'd1;
            end
            if (flush) begin
                m_gh = {q_gh[0][GH_WIDTH-2:0], resolve_taken};
                q_gh.delete();
                q_taken.delete();
                q_idx.delete();
                q_pc.delete();
            end else begin
                void'(q_gh.pop_front());
                void'(q_taken.pop_front());
                void'(q_idx.pop_front());
                void'(q_pc.pop_front());
            end
        end
        if (!flush && m_pv) begin
            q_gh.push_back(m_ph);
            q_taken.push_back(m_pt);
            q_idx.push_back(m_pidx);
            q_pc.push_back(m_ppc);
            m_gh = gh_cur;
        end
        if (q_gh.size() > int'(CKPT_DEPTH)) begin
            report_fault("checkpoint queue holds more entries than its depth");
        end
        m_pv = fire;
        if (fire) begin
            m_pt   = (ctr >= 2'd2);
            m_pidx = idx;
            m_ph   = gh_cur;
            m_ppc  = m_f_pc;
        end
        if (flush) begin
            m_f_valid = 1'b0;
        end else if (!stall) begin
            m_f_valid = fetch_valid;
            if (fetch_valid) begin
                m_f_pc = fetch_pc;
            end
        end
        m_redirect = flush;
        if (m_init_busy) begin
            m_init_left--;
            m_init_busy = (m_init_left != 0);
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rstn) begin
            reset_model();
        end else begin
            compare("redirect", 32'(m_redirect), 32'(redirect));
            compare("ckpt_room", 32'(room_now()), 32'(ckpt_room));
            compare("pred_valid", 32'(m_pv), 32'(pred_valid));
            if (m_pv) begin
                compare("pred_taken", 32'(m_pt), 32'(pred_taken));
                compare("pred_hist", 32'(m_ph), 32'(pred_hist));
            end
            step_model();
            model_room  = room_now();
            model_count = q_gh.size();
            oldest_pc   = (q_pc.size() != 0) ? q_pc[0] : '0;
        end
        if (test_done) begin
            $display("test %s: %0d checks, %0d mismatches",
                     test_name(test_id), test_checks, test_errors);
            test_checks = 0;
            test_errors = 0;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_bp_top.sv ====
// gshare predictor testbench
`timescale 1ns/10ps
`default_nettype none

module tb_bp_top;
    import bp_cfg_pkg::*;

    localparam int unsigned GH_WIDTH   = GH_WIDTH_DEF;
    localparam int unsigned CKPT_DEPTH = CKPT_DEPTH_DEF;
    localparam int HALF_PERIOD  = 4;        // 8 ns clock
    localparam int RESET_CYCLES = 10;
    localparam int C_COLD       = 40;
    localparam int C_TRAIN      = 300;
    localparam int C_STEADY     = 300;
    localparam int C_MISS       = 300;
    localparam int C_STALL      = 400;
    localparam int STIM_CYCLES  = C_COLD + C_TRAIN + C_STEADY + C_MISS + C_STALL;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + PHT_DEPTH + STIM_CYCLES + 200;
    localparam logic [31:0] PC_BASE   = 32'h0000_4000;
    localparam logic [31:0] PC_STRIDE = 32'h0000_0044;

    logic                clk;
    logic                rstn;
    logic                fetch_valid;
    logic [PC_WIDTH-1:0] fetch_pc;
    logic                stall;
    logic                resolve_valid;
    logic                resolve_taken;
    logic                pred_valid;
    logic                pred_taken;
    logic [GH_WIDTH-1:0] pred_hist;
    logic                redirect;
    logic                ckpt_room;
    logic [2:0]          test_id;
    logic                test_done;
    logic                model_room;
    int                  model_count;
    logic [PC_WIDTH-1:0] oldest_pc;
    int                  check_count;
    int                  error_count;
    logic [31:0]         lfsr;

    bp_top #(
        .GH_WIDTH   (GH_WIDTH),
        .CKPT_DEPTH (CKPT_DEPTH)
    ) u_dut (
        .clk           (clk),
        .rstn          (rstn),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .stall         (stall),
        .resolve_valid (resolve_valid),
        .resolve_taken (resolve_taken),
        .pred_valid    (pred_valid),
        .pred_taken    (pred_taken),
        .pred_hist     (pred_hist),
        .redirect      (redirect),
        .ckpt_room     (ckpt_room)
    );

    bp_checker #(
        .GH_WIDTH   (GH_WIDTH),
        .CKPT_DEPTH (CKPT_DEPTH)
    ) u_chk (
        .clk           (clk),
        .rstn          (rstn),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .stall         (stall),
        .resolve_valid (resolve_valid),
        .resolve_taken (resolve_taken),
        .pred_valid    (pred_valid),
        .pred_taken    (pred_taken),
        .pred_hist     (pred_hist),
        .redirect      (redirect),
        .ckpt_room     (ckpt_room),
        .test_id       (test_id),
        .test_done     (test_done),
        .model_room    (model_room),
        .model_count   (model_count),
        .oldest_pc     (oldest_pc),
        .check_count   (check_count),
        .error_count   (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic pattern_taken(input logic [PC_WIDTH-1:0] pc);
        return pc[4] ^ pc[7];   // fixed direction per pc
    endfunction

    // thresholds are out of 16
    task automatic run_test(input logic [2:0] id, input int cycles, input int fetch_th,
                            input int stall_th, input int res_th, input int flip_th);
        logic [31:0] r;
        logic        res;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            test_id   <= id;
            test_done <= (c == cycles - 1);
            draw(4, r);
            stall <= (int'(r) < stall_th);
            draw(4, r);
            fetch_valid <= model_room && (int'(r) < fetch_th);
            draw(3, r);
            fetch_pc <= PC_BASE + r * PC_STRIDE;        // small pool, indices repeat
            draw(4, r);
            res = (model_count != 0) && (int'(r) < res_th);
            resolve_valid <= res;
            draw(4, r);
            resolve_taken <= res && (pattern_taken(oldest_pc) ^ (int'(r) < flip_th));
        end
    endtask

    initial begin
        rstn          = 1'b0;
        fetch_valid   = 1'b0;
        fetch_pc      = '0;
        stall         = 1'b0;
        resolve_valid = 1'b0;
        resolve_taken = 1'b0;
        test_id       = 3'd0;
        test_done     = 1'b0;
        lfsr          = 32'd90384;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        while (!ckpt_room) @(negedge clk);      // table walk
        run_test(3'd1, C_COLD, 16, 0, 0, 0);
        run_test(3'd2, C_TRAIN, 8, 0, 12, 0);
        run_test(3'd3, C_STEADY, 12, 0, 10, 0);
        run_test(3'd4, C_MISS, 12, 2, 10, 5);
        run_test(3'd5, C_STALL, 12, 7, 9, 2);
        @(posedge clk);
        test_done     <= 1'b0;
        fetch_valid   <= 1'b0;
        resolve_valid <= 1'b0;
        stall         <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        #(HALF_PERIOD / 2);     // past the last negedge comparison
        $display("summary: 5 tests, %0d checks, %0d mismatches, %0d assertion failures",
                 check_count, error_count, u_dut.u_props.fail_count);
        if (error_count == 0 && u_dut.u_props.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
        $display("watchdog: run did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/bp_cfg_pkg.sv
hdl/bp_types_pkg.sv
hdl/bp_pht.sv
hdl/bp_fetch_stage.sv
hdl/bp_predict_stage.sv
hdl/bp_ghr_ckpt.sv
hdl/bp_top.sv
sim/bp_properties.sv
sim/bp_checker.sv
sim/tb_bp_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_bp_top
FILELIST  := verilog.f
VFLAGS    := --binary --timing --assert -Wno-fatal
SIM_ARGS  := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard hdl/*.sv sim/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
